// File: flist.f
source/rv_isa_pkg.sv
source/exu_pipe_pkg.sv
source/exu_if.sv
source/operand_bypass.sv
source/alu.sv
source/redirect_unit.sv
source/exu_output_stage.sv
source/exu_top.sv
sim/exu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module exu_tb -f flist.f -o exu_sim \
    && ./obj_dir/exu_sim | tee /dev/stderr | grep -q "^TEST PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_INSTR  = 2000;
    localparam int TIMEOUT_NS = NUM_INSTR * CLK_PERIOD * 8;

    logic clk = 1'b0;
    logic rst;
    logic idu_valid, lsu_ready, gpr_we, src1_is_pc, src2_is_imm;
    logic is_load, is_store, ecall, mret, load_done, pc_update;
    logic [XLEN-1:0] pc, imm, src1_reg, src2_reg, csr_data, load_data;
    logic [REG_W-1:0] rd, rs1, rs2;
    logic [ALU_OP_W-1:0] alu_op;
    logic [BR_W-1:0] br_cond;
    logic [CSR_W-1:0] csr_op;
    logic exu_ready, exu_valid, redirect_valid, out_gpr_we, out_is_load, out_is_store;
    logic [XLEN-1:0] redirect_pc, out_pc, out_result, out_store_data, out_csr_wdata;
    logic [REG_W-1:0] out_rd;

    // Reference model state
    logic [REG_W-1:0] model_rd   [BYPASS_DEPTH];
    logic [XLEN-1:0]  model_data [BYPASS_DEPTH];
    logic             model_load [BYPASS_DEPTH];
    logic             model_redirect;
    logic [XLEN-1:0]  model_redirect_pc;
    logic exp_fire, exp_gpr_we, exp_is_load, exp_is_store, accepted;
    logic [XLEN-1:0] exp_pc, exp_result, exp_store, exp_csr;
    logic [REG_W-1:0] exp_rd;
    int seed = 54;
    int n_errors = 0;
    int n_checks = 0;
    int n_accept = 0;
    int load_delay = 0;
    int update_delay = 0;

    exu_top exu_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_redirect(input logic got_valid, input logic [XLEN-1:0] got_pc,
                                  input logic exp_valid, input logic [XLEN-1:0] exp_pc_v);
        n_checks++;
        if (got_valid !== exp_valid || got_pc !== exp_pc_v) begin
            n_errors++;
            $display("Mismatch at %0t: redirect is %b/%h, expected %b/%h",
                     $time, got_valid, got_pc, exp_valid, exp_pc_v);
        end
    endtask

    function automatic logic [XLEN-1:0] alu_model(input logic [ALU_OP_W-1:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLL:   return a << b[4:0];
            ALU_SLT:   return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            ALU_SLTU:  return (a < b) ? XLEN'(1) : '0;
            ALU_XOR:   return a ^ b;
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:    return a | b;
            ALU_AND:   return a & b;
            ALU_PASS2: return b;
            default:   return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [BR_W-1:0] cond,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        case (cond)
            BR_EQ:           return a == b;
            BR_NE:           return a != b;
            BR_LT:           return $signed(a) < $signed(b);
            BR_GE:           return !($signed(a) < $signed(b));
            BR_LTU:          return a < b;
            BR_GEU:          return !(a < b);
            BR_JAL, BR_JALR: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic logic load_pending();
        logic any;
        any = 1'b0;
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            any = any | model_load[i];
        end
        return any;
    endfunction

    // Newest matching history entry or else the register file value
    task automatic forward(input logic [REG_W-1:0] rs, input logic [XLEN-1:0] reg_val,
                           output logic [XLEN-1:0] val, output logic waiting);
        logic found;
        found   = 1'b0;
        val     = reg_val;
        waiting = 1'b0;
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            if (!found && rs != '0 && model_rd[i] == rs) begin
                found   = 1'b1;
                val     = model_data[i];
                waiting = model_load[i];
            end
        end
    endtask

    task automatic new_instruction();
        int kind;
        idu_valid   = ({$random(seed)} % 8) != 0;
        pc          = $random(seed) & 32'hffff_fffc;
        imm         = $random(seed);
        rd          = REG_W'({$random(seed)} % 4);  // Small indices so forwarding hits often
        rs1         = REG_W'({$random(seed)} % 4);
        rs2         = REG_W'({$random(seed)} % 4);
        src1_reg    = $random(seed);
        src2_reg    = (({$random(seed)} % 4) == 0) ? src1_reg : $random(seed);
        gpr_we      = ({$random(seed)} % 4) != 0;
        alu_op      = ALU_OP_W'({$random(seed)} % 11);
        src1_is_pc  = ($random(seed) & 1) != 0;
        src2_is_imm = ($random(seed) & 1) != 0;
        csr_data    = $random(seed);
        br_cond     = BR_NONE;
        csr_op      = CSR_NONE;
        is_load     = 1'b0;
        is_store    = 1'b0;
        ecall       = 1'b0;
        mret        = 1'b0;
        kind = {$random(seed)} % 16;
        case (kind)
            0, 1, 2: begin
                br_cond = BR_W'(1 + {$random(seed)} % 8);
                imm     = XLEN'({$random(seed)} % 8) << 2;  // Offset 4 gives no redirect
            end
            3, 4: is_load = 1'b1;
            5: is_store = 1'b1;
            6: csr_op = CSR_RW;
            7: csr_op = CSR_RS;
            8: begin
                ecall = ($random(seed) & 1) != 0;
                mret  = !ecall;
            end
            default: ;
        endcase
    endtask

    task automatic drive_inputs();
        load_done = 1'b0;
        pc_update = 1'b0;
        if (load_delay == 0 && load_pending()) load_delay = 1 + {$random(seed)} % 3;
        if (load_delay > 0) begin
            load_delay--;
            if (load_delay == 0) begin
                load_done = 1'b1;
                load_data = $random(seed);
            end
        end
        if (update_delay == 0 && model_redirect) update_delay = 2 + {$random(seed)} % 3;
        if (update_delay > 0) begin
            update_delay--;
            pc_update = (update_delay == 0);
        end
        lsu_ready = ({$random(seed)} % 10) >= 2;
        if (!(idu_valid && !accepted)) new_instruction();  // Decode holds until accepted
    endtask

    // Runs mid-cycle on stable inputs and advances the model across the next edge
    task automatic model_step();
        logic [XLEN-1:0] a1, a2, res, target;
        logic w1, w2, fire, taken;
        forward(rs1, src1_reg, a1, w1);
        forward(rs2, src2_reg, a2, w2);
        check_flag(exu_ready, lsu_ready && !(w1 || w2), "exu_ready");
        accepted = idu_valid && exu_ready;
        fire     = accepted && !model_redirect;
        if (accepted) n_accept++;
        if (br_cond == BR_JAL || br_cond == BR_JALR) res = pc + XLEN'(PC_STEP);
        else if (csr_op != CSR_NONE) res = csr_data;
        else res = alu_model(alu_op, src1_is_pc ? pc : a1, src2_is_imm ? imm : a2);
        if (ecall || mret) target = csr_data;
        else if (br_cond == BR_JALR) target = (a1 + imm) & ~XLEN'(1);
        else target = pc + imm;
        taken    = branch_taken(br_cond, a1, a2) || ecall || mret;
        exp_fire = fire;
        if (fire) begin
            exp_pc       = pc;
            exp_rd       = rd;
            exp_result   = res;
            exp_store    = a2;
            exp_gpr_we   = gpr_we;
            exp_is_load  = is_load;
            exp_is_store = is_store;
            case (csr_op)
                CSR_RW:  exp_csr = a1;
                CSR_RS:  exp_csr = a1 | csr_data;
                default: exp_csr = '0;
            endcase
        end
        if (model_redirect) begin
            if (pc_update) begin
                model_redirect    = 1'b0;
                model_redirect_pc = '0;
            end
        end else if (accepted && taken && target != pc + XLEN'(PC_STEP)) begin
            model_redirect    = 1'b1;
            model_redirect_pc = target;
        end
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            if (load_done && model_load[i]) model_data[i] = load_data;
            if (load_done) model_load[i] = 1'b0;
        end
        if (fire && gpr_we) begin
            for (int i = BYPASS_DEPTH - 1; i > 0; i--) begin
                model_rd[i]   = model_rd[i-1];
                model_data[i] = model_data[i-1];
                model_load[i] = model_load[i-1];
            end
            model_rd[0]   = rd;
            model_data[0] = is_load ? '0 : res;
            model_load[0] = is_load;
        end
    endtask

    task automatic check_outputs();
        check_flag(exu_valid, exp_fire, "exu_valid");
        if (exp_fire) begin
            check_word(out_pc, exp_pc, "out_pc");
            check_word(XLEN'(out_rd), XLEN'(exp_rd), "out_rd");
            check_flag(out_gpr_we, exp_gpr_we, "out_gpr_we");
            check_flag(out_is_load, exp_is_load, "out_is_load");
            check_flag(out_is_store, exp_is_store, "out_is_store");
            check_word(out_result, exp_result, "out_result");
            check_word(out_store_data, exp_store, "out_store_data");
            check_word(out_csr_wdata, exp_csr, "out_csr_wdata");
        end
        check_redirect(redirect_valid, redirect_pc, model_redirect, model_redirect_pc);
    endtask

    // Control outputs must be cleared while reset is held
    task automatic check_reset_state();
        check_flag(exu_valid, 1'b0, "exu_valid in reset");
        check_flag(out_gpr_we, 1'b0, "out_gpr_we in reset");
        check_flag(out_is_load, 1'b0, "out_is_load in reset");
        check_flag(out_is_store, 1'b0, "out_is_store in reset");
        check_redirect(redirect_valid, redirect_pc, 1'b0, '0);
    endtask

    initial begin
        rst = 1'b1;
        {idu_valid, lsu_ready, gpr_we, src1_is_pc, src2_is_imm} = 5'b0;
        {is_load, is_store, ecall, mret, load_done, pc_update} = 6'b0;
        {pc, imm, src1_reg, src2_reg, csr_data, load_data} = '0;
        {rd, rs1, rs2} = '0;
        alu_op  = ALU_ADD;
        br_cond = BR_NONE;
        csr_op  = CSR_NONE;
        {model_redirect, model_redirect_pc, exp_fire, accepted} = '0;
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            {model_rd[i], model_data[i], model_load[i]} = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        check_reset_state();
        #1;
        rst = 1'b0;
        while (n_accept < NUM_INSTR) begin
            drive_inputs();
            @(negedge clk);
            model_step();
            @(posedge clk);
            #1;
            check_outputs();
            #1;
        end
        $display("Checks: %0d, mismatches: %0d, accepted: %0d", n_checks, n_errors, n_accept);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #TIMEOUT_NS;
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          idu_valid,
    output logic                          exu_ready,
    input  logic                          lsu_ready,
    output logic                          exu_valid,
    input  logic [rv_isa_pkg::XLEN-1:0]   pc,
    input  logic [rv_isa_pkg::XLEN-1:0]   imm,
    input  logic [rv_isa_pkg::REG_W-1:0]  rd,
    input  logic [rv_isa_pkg::REG_W-1:0]  rs1,
    input  logic [rv_isa_pkg::REG_W-1:0]  rs2,
    input  logic [rv_isa_pkg::XLEN-1:0]   src1_reg,
    input  logic [rv_isa_pkg::XLEN-1:0]   src2_reg,
    input  logic                          gpr_we,
    input  logic [rv_isa_pkg::ALU_OP_W-1:0] alu_op,
    input  logic                          src1_is_pc,
    input  logic                          src2_is_imm,
    input  logic [rv_isa_pkg::BR_W-1:0]   br_cond,
    input  logic                          is_load,
    input  logic                          is_store,
    input  logic                          ecall,
    input  logic                          mret,
    input  logic [rv_isa_pkg::CSR_W-1:0]  csr_op,
    input  logic [rv_isa_pkg::XLEN-1:0]   csr_data,
    input  logic                          load_done,
    input  logic [rv_isa_pkg::XLEN-1:0]   load_data,
    input  logic                          pc_update,
    output logic                          redirect_valid,
    output logic [rv_isa_pkg::XLEN-1:0]   redirect_pc,
    output logic [rv_isa_pkg::XLEN-1:0]   out_pc,
    output logic [rv_isa_pkg::REG_W-1:0]  out_rd,
    output logic                          out_gpr_we,
    output logic                          out_is_load,
    output logic                          out_is_store,
    output logic [rv_isa_pkg::XLEN-1:0]   out_result,
    output logic [rv_isa_pkg::XLEN-1:0]   out_store_data,
    output logic [rv_isa_pkg::XLEN-1:0]   out_csr_wdata
);
    logic accept;
    logic load_wait;
    logic [rv_isa_pkg::XLEN-1:0] alu_result;

    operand_if ops ();
    result_if  wr_bus ();

    assign ops.rs1      = rs1;
    assign ops.rs2      = rs2;
    assign ops.src1_reg = src1_reg;
    assign ops.src2_reg = src2_reg;

    operand_bypass operand_bypass_i (
        .clk       (clk),
        .rst       (rst),
        .load_done (load_done),
        .load_data (load_data),
        .ops       (ops.bypass),
        .wr        (wr_bus.bypass),
        .load_wait (load_wait)
    );

    alu alu_i (
        .op          (alu_op),
        .pc          (pc),
        .imm         (imm),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .ops         (ops.alu),
        .result      (alu_result)
    );

    redirect_unit redirect_unit_i (
        .clk            (clk),
        .rst            (rst),
        .accept         (accept),
        .pc             (pc),
        .imm            (imm),
        .br_cond        (br_cond),
        .ecall          (ecall),
        .mret           (mret),
        .csr_data       (csr_data),
        .pc_update      (pc_update),
        .ops            (ops.redirect),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    exu_output_stage exu_output_stage_i (
        .clk            (clk),
        .rst            (rst),
        .idu_valid      (idu_valid),
        .lsu_ready      (lsu_ready),
        .load_wait      (load_wait),
        .redirect_valid (redirect_valid),
        .pc             (pc),
        .rd             (rd),
        .gpr_we         (gpr_we),
        .is_load        (is_load),
        .is_store       (is_store),
        .br_cond        (br_cond),
        .csr_op         (csr_op),
        .csr_data       (csr_data),
        .alu_result     (alu_result),
        .ops            (ops.redirect),
        .wr             (wr_bus.output_stage),
        .exu_ready      (exu_ready),
        .accept         (accept),
        .exu_valid      (exu_valid),
        .out_pc         (out_pc),
        .out_rd         (out_rd),
        .out_gpr_we     (out_gpr_we),
        .out_is_load    (out_is_load),
        .out_is_store   (out_is_store),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .out_csr_wdata  (out_csr_wdata)
    );

endmodule

`default_nettype wire

// File: source/exu_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exu_output_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         idu_valid,
    input  logic                         lsu_ready,
    input  logic                         load_wait,
    input  logic                         redirect_valid,
    input  logic [rv_isa_pkg::XLEN-1:0]  pc,
    input  logic [rv_isa_pkg::REG_W-1:0] rd,
    input  logic                         gpr_we,
    input  logic                         is_load,
    input  logic                         is_store,
    input  logic [rv_isa_pkg::BR_W-1:0]  br_cond,
    input  logic [rv_isa_pkg::CSR_W-1:0] csr_op,
    input  logic [rv_isa_pkg::XLEN-1:0]  csr_data,
    input  logic [rv_isa_pkg::XLEN-1:0]  alu_result,
    operand_if.redirect                  ops,
    result_if.output_stage               wr,
    output logic                         exu_ready,
    output logic                         accept,
    output logic                         exu_valid,
    output logic [rv_isa_pkg::XLEN-1:0]  out_pc,
    output logic [rv_isa_pkg::REG_W-1:0] out_rd,
    output logic                         out_gpr_we,
    output logic                         out_is_load,
    output logic                         out_is_store,
    output logic [rv_isa_pkg::XLEN-1:0]  out_result,
    output logic [rv_isa_pkg::XLEN-1:0]  out_store_data,
    output logic [rv_isa_pkg::XLEN-1:0]  out_csr_wdata
);
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;

    logic            fire;
    logic            is_jump;
    logic            is_csr;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] csr_wdata;

    assign exu_ready = lsu_ready && !load_wait;
    assign accept    = idu_valid && exu_ready;
    assign fire      = accept && !redirect_valid;  // Wrong-path instructions die here
    assign is_jump   = (br_cond == BR_JAL) || (br_cond == BR_JALR);
    assign is_csr    = (csr_op != CSR_NONE);

    // For loads and stores the ALU result is the address
    always_comb begin
        if (is_jump) begin
            result = pc + XLEN'(PC_STEP);
        end else if (is_csr) begin
            result = csr_data;
        end else begin
            result = alu_result;
        end
    end

    always_comb begin
        case (csr_op)
            CSR_RW:  csr_wdata = ops.src1;
            CSR_RS:  csr_wdata = ops.src1 | csr_data;
            default: csr_wdata = '0;
        endcase
    end

    assign wr.wr_en      = fire && gpr_we;
    assign wr.wr_rd      = rd;
    assign wr.wr_data    = is_load ? '0 : result;  // Real value arrives with load_done
    assign wr.wr_is_load = is_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid    <= 1'b0;
            out_gpr_we   <= 1'b0;
            out_is_load  <= 1'b0;
            out_is_store <= 1'b0;
        end else begin
            exu_valid <= fire;
            if (fire) begin
                out_gpr_we   <= gpr_we;
                out_is_load  <= is_load;
                out_is_store <= is_store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc         <= pc;
            out_rd         <= rd;
            out_result     <= result;
            out_store_data <= ops.src2;
            out_csr_wdata  <= csr_wdata;
        end
    end

endmodule

`default_nettype wire

// File: source/redirect_unit.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        accept,
    input  logic [rv_isa_pkg::XLEN-1:0] pc,
    input  logic [rv_isa_pkg::XLEN-1:0] imm,
    input  logic [rv_isa_pkg::BR_W-1:0] br_cond,
    input  logic                        ecall,
    input  logic                        mret,
    input  logic [rv_isa_pkg::XLEN-1:0] csr_data,
    input  logic                        pc_update,
    operand_if.redirect                 ops,
    output logic                        redirect_valid,
    output logic [rv_isa_pkg::XLEN-1:0] redirect_pc
);
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;

    logic            cond_met;
    logic            taken;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] seq_pc;

    assign seq_pc   = pc + XLEN'(PC_STEP);
    assign jalr_sum = ops.src1 + imm;

    always_comb begin
        case (br_cond)
            BR_EQ:   cond_met = (ops.src1 == ops.src2);
            BR_NE:   cond_met = (ops.src1 != ops.src2);
            BR_LT:   cond_met = ($signed(ops.src1) < $signed(ops.src2));
            BR_GE:   cond_met = ($signed(ops.src1) >= $signed(ops.src2));
            BR_LTU:  cond_met = (ops.src1 < ops.src2);
            BR_GEU:  cond_met = (ops.src1 >= ops.src2);
            BR_JAL:  cond_met = 1'b1;
            BR_JALR: cond_met = 1'b1;
            BR_NONE: cond_met = 1'b0;
            default: cond_met = 1'b0;
        endcase
    end

    assign taken = cond_met || ecall || mret;

    always_comb begin
        if (ecall || mret) begin
            target = csr_data;                     // mtvec or mepc as read by decode
        end else if (br_cond == BR_JALR) begin
            target = {jalr_sum[XLEN-1:1], 1'b0};
        end else begin
            target = pc + imm;
        end
    end

    // A held redirect blocks new ones until fetch confirms with pc_update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else if (redirect_valid) begin
            if (pc_update) begin
                redirect_valid <= 1'b0;
                redirect_pc    <= '0;
            end
        end else if (accept && taken && (target != seq_pc)) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= target;
        end
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_isa_pkg::ALU_OP_W-1:0] op,
    input  logic [rv_isa_pkg::XLEN-1:0]     pc,
    input  logic [rv_isa_pkg::XLEN-1:0]     imm,
    input  logic                            src1_is_pc,
    input  logic                            src2_is_imm,
    operand_if.alu                          ops,
    output logic [rv_isa_pkg::XLEN-1:0]     result
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [4:0]      shamt;

    assign a     = src1_is_pc ? pc : ops.src1;    // auipc and jal add to the pc
    assign b     = src2_is_imm ? imm : ops.src2;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, a < b};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_PASS2: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_done,
    input  logic [rv_isa_pkg::XLEN-1:0] load_data,
    operand_if.bypass                   ops,
    result_if.bypass                    wr,
    output logic                        load_wait
);
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;

    logic [REG_W-1:0] hist_rd   [BYPASS_DEPTH];
    logic [XLEN-1:0]  hist_data [BYPASS_DEPTH];
    logic             hist_load [BYPASS_DEPTH];

    logic [XLEN-1:0]  done_data [BYPASS_DEPTH];
    logic             done_load [BYPASS_DEPTH];
    logic             wait1;
    logic             wait2;

    // Every pending load takes the returned word before the shift
    always_comb begin
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            done_data[i] = (load_done && hist_load[i]) ? load_data : hist_data[i];
            done_load[i] = hist_load[i] && !load_done;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist_rd[i]   <= '0;
                hist_load[i] <= 1'b0;
            end
        end else if (wr.wr_en) begin
            hist_rd[0]   <= wr.wr_rd;
            hist_load[0] <= wr.wr_is_load;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                hist_rd[i]   <= hist_rd[i-1];
                hist_load[i] <= done_load[i-1];
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist_load[i] <= done_load[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            hist_data[0] <= wr.wr_data;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                hist_data[i] <= done_data[i-1];
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist_data[i] <= done_data[i];
            end
        end
    end

    // Walk from oldest to newest so the newest match wins
    always_comb begin
        ops.src1 = ops.src1_reg;
        ops.src2 = ops.src2_reg;
        wait1    = 1'b0;
        wait2    = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if ((hist_rd[i] == ops.rs1) && (ops.rs1 != '0)) begin
                ops.src1 = hist_data[i];
                wait1    = hist_load[i];
            end
            if ((hist_rd[i] == ops.rs2) && (ops.rs2 != '0)) begin
                ops.src2 = hist_data[i];
                wait2    = hist_load[i];
            end
        end
    end

    assign load_wait = wait1 || wait2;

endmodule

`default_nettype wire

// File: source/exu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface operand_if;
    import rv_isa_pkg::*;

    logic [XLEN-1:0]  src1;      // Operands after forwarding
    logic [XLEN-1:0]  src2;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [XLEN-1:0]  src1_reg;  // Register file values read by decode
    logic [XLEN-1:0]  src2_reg;

    modport bypass (
        output src1,
        output src2,
        input  rs1,
        input  rs2,
        input  src1_reg,
        input  src2_reg
    );

    modport alu (
        input src1,
        input src2
    );

    modport redirect (
        input src1,
        input src2
    );
endinterface

interface result_if;
    import rv_isa_pkg::*;

    logic             wr_en;
    logic [REG_W-1:0] wr_rd;
    logic [XLEN-1:0]  wr_data;
    logic             wr_is_load;

    modport output_stage (
        output wr_en,
        output wr_rd,
        output wr_data,
        output wr_is_load
    );

    modport bypass (
        input wr_en,
        input wr_rd,
        input wr_data,
        input wr_is_load
    );
endinterface

`default_nettype wire

// File: source/exu_pipe_pkg.sv
`default_nettype none

package exu_pipe_pkg;

    // Recent register writes kept for forwarding with entry 0 as the newest
    localparam int BYPASS_DEPTH = 4;

    localparam int PC_STEP = 4;  // No compressed instructions

endpackage

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 4;  // RV32E has sixteen registers

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS2 = 4'd10;  // Operand 2 straight through for lui

    localparam int BR_W = 4;  // Nine conditions do not fit in three bits

    localparam logic [BR_W-1:0] BR_NONE = 4'd0;
    localparam logic [BR_W-1:0] BR_EQ   = 4'd1;
    localparam logic [BR_W-1:0] BR_NE   = 4'd2;
    localparam logic [BR_W-1:0] BR_LT   = 4'd3;
    localparam logic [BR_W-1:0] BR_GE   = 4'd4;
    localparam logic [BR_W-1:0] BR_LTU  = 4'd5;
    localparam logic [BR_W-1:0] BR_GEU  = 4'd6;
    localparam logic [BR_W-1:0] BR_JAL  = 4'd7;
    localparam logic [BR_W-1:0] BR_JALR = 4'd8;

    localparam int CSR_W = 2;

    localparam logic [CSR_W-1:0] CSR_NONE = 2'd0;
    localparam logic [CSR_W-1:0] CSR_RW   = 2'd1;
    localparam logic [CSR_W-1:0] CSR_RS   = 2'd2;

endpackage

`default_nettype wire
